//--- verilog/axi_config.svh
`ifndef AXI_CONFIG_SVH
`define AXI_CONFIG_SVH

// axi-lite bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4

// on-chip word ram window
`define RAM_BASE  32'h8000_0000
`define RAM_WORDS 256

`endif

//--- verilog/axi_pkg.sv
`default_nettype none

`include "axi_config.svh"

package axi_pkg;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_DATA_W-1:0] data_t;
    typedef logic [`AXI_STRB_W-1:0] strb_t;

    // only the two responses this fabric produces
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic {
        GRANT_FETCH,
        GRANT_LSU
    } grant_e;

    typedef enum logic [1:0] {
        XB_IDLE,
        XB_RAM,
        XB_ERR_R,
        XB_ERR_B
    } xbar_state_e;

endpackage

`default_nettype wire

//--- verilog/arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter (
    input  logic            clk,
    input  logic            rst_n,

    // fetch master, read only
    input  axi_pkg::addr_t  fetch_araddr,
    input  logic            fetch_arvalid,
    output logic            fetch_arready,
    output axi_pkg::data_t  fetch_rdata,
    output axi_pkg::resp_e  fetch_rresp,
    output logic            fetch_rvalid,
    input  logic            fetch_rready,

    // lsu master
    input  axi_pkg::addr_t  lsu_araddr,
    input  logic            lsu_arvalid,
    output logic            lsu_arready,
    output axi_pkg::data_t  lsu_rdata,
    output axi_pkg::resp_e  lsu_rresp,
    output logic            lsu_rvalid,
    input  logic            lsu_rready,
    input  axi_pkg::addr_t  lsu_awaddr,
    input  logic            lsu_awvalid,
    output logic            lsu_awready,
    input  axi_pkg::data_t  lsu_wdata,
    input  axi_pkg::strb_t  lsu_wstrb,
    input  logic            lsu_wvalid,
    output logic            lsu_wready,
    output axi_pkg::resp_e  lsu_bresp,
    output logic            lsu_bvalid,
    input  logic            lsu_bready,

    // toward the xbar
    output axi_pkg::addr_t  arb_araddr,
    output logic            arb_arvalid,
    input  logic            arb_arready,
    input  axi_pkg::data_t  arb_rdata,
    input  axi_pkg::resp_e  arb_rresp,
    input  logic            arb_rvalid,
    output logic            arb_rready,
    output axi_pkg::addr_t  arb_awaddr,
    output logic            arb_awvalid,
    input  logic            arb_awready,
    output axi_pkg::data_t  arb_wdata,
    output axi_pkg::strb_t  arb_wstrb,
    output logic            arb_wvalid,
    input  logic            arb_wready,
    input  axi_pkg::resp_e  arb_bresp,
    input  logic            arb_bvalid,
    output logic            arb_bready
);

    axi_pkg::grant_e grant;
    axi_pkg::grant_e next_grant;
    logic            armed;
    logic            busy;
    logic            any_req;
    logic            sel_lsu;
    logic            aw_fwd;
    logic            req_hs;
    logic            rsp_hs;

    assign any_req = fetch_arvalid | lsu_arvalid | lsu_awvalid;

    // lsu beats fetch, no request keeps the current owner
    always_comb begin
        if (lsu_arvalid || lsu_awvalid) begin
            next_grant = axi_pkg::GRANT_LSU;
        end else if (fetch_arvalid) begin
            next_grant = axi_pkg::GRANT_FETCH;
        end else begin
            next_grant = grant;
        end
    end

    // idle -> armed (grant latched) -> busy (request accepted) -> idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= axi_pkg::GRANT_FETCH;
            armed <= 1'b0;
            busy  <= 1'b0;
        end else if (busy) begin
            if (rsp_hs) begin
                busy <= 1'b0;
            end
        end else if (armed) begin
            if (req_hs) begin
                armed <= 1'b0;
                busy  <= 1'b1;
            end
        end else if (any_req) begin
            grant <= next_grant;
            armed <= 1'b1;
        end
    end

    assign sel_lsu = (grant == axi_pkg::GRANT_LSU);
    // a pending lsu read goes out before its write
    assign aw_fwd  = armed & sel_lsu & ~lsu_arvalid;

    assign req_hs = (arb_arvalid & arb_arready) | (arb_awvalid & arb_awready);
    assign rsp_hs = (arb_rvalid & arb_rready) | (arb_bvalid & arb_bready);

    // request side, only while armed
    assign arb_araddr  = sel_lsu ? lsu_araddr : fetch_araddr;
    assign arb_arvalid = armed & (sel_lsu ? lsu_arvalid : fetch_arvalid);
    assign arb_awaddr  = lsu_awaddr;
    assign arb_awvalid = aw_fwd & lsu_awvalid;
    assign arb_wdata   = lsu_wdata;
    assign arb_wstrb   = lsu_wstrb;
    assign arb_wvalid  = aw_fwd & lsu_wvalid;

    // response side, only while busy
    assign arb_rready = busy & (sel_lsu ? lsu_rready : fetch_rready);
    assign arb_bready = busy & sel_lsu & lsu_bready;

    assign fetch_arready = armed & ~sel_lsu & arb_arready;
    assign fetch_rdata   = arb_rdata;
    assign fetch_rresp   = arb_rresp;
    assign fetch_rvalid  = busy & ~sel_lsu & arb_rvalid;

    assign lsu_arready = armed & sel_lsu & arb_arready;
    assign lsu_rdata   = arb_rdata;
    assign lsu_rresp   = arb_rresp;
    assign lsu_rvalid  = busy & sel_lsu & arb_rvalid;
    assign lsu_awready = aw_fwd & arb_awready;
    assign lsu_wready  = aw_fwd & arb_wready;
    assign lsu_bresp   = arb_bresp;
    assign lsu_bvalid  = busy & sel_lsu & arb_bvalid;

    // a response only comes back for a request the owner got accepted
    a_rsp_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (arb_rvalid || arb_bvalid) |-> busy);

endmodule

`default_nettype wire

//--- verilog/xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module xbar (
    input  logic            clk,
    input  logic            rst_n,

    // from the arbiter
    input  axi_pkg::addr_t  arb_araddr,
    input  logic            arb_arvalid,
    output logic            arb_arready,
    output axi_pkg::data_t  arb_rdata,
    output axi_pkg::resp_e  arb_rresp,
    output logic            arb_rvalid,
    input  logic            arb_rready,
    input  axi_pkg::addr_t  arb_awaddr,
    input  logic            arb_awvalid,
    output logic            arb_awready,
    input  axi_pkg::data_t  arb_wdata,
    input  axi_pkg::strb_t  arb_wstrb,
    input  logic            arb_wvalid,
    output logic            arb_wready,
    output axi_pkg::resp_e  arb_bresp,
    output logic            arb_bvalid,
    input  logic            arb_bready,

    // to the word ram
    output axi_pkg::addr_t  ram_araddr,
    output logic            ram_arvalid,
    input  logic            ram_arready,
    input  axi_pkg::data_t  ram_rdata,
    input  axi_pkg::resp_e  ram_rresp,
    input  logic            ram_rvalid,
    output logic            ram_rready,
    output axi_pkg::addr_t  ram_awaddr,
    output logic            ram_awvalid,
    input  logic            ram_awready,
    output axi_pkg::data_t  ram_wdata,
    output axi_pkg::strb_t  ram_wstrb,
    output logic            ram_wvalid,
    input  logic            ram_wready,
    input  axi_pkg::resp_e  ram_bresp,
    input  logic            ram_bvalid,
    output logic            ram_bready
);

    axi_pkg::xbar_state_e state;
    logic                 st_idle;
    logic                 st_ram;
    logic                 st_err_r;
    logic                 st_err_b;
    logic                 ar_hit;
    logic                 aw_hit;
    logic                 wr_sel;
    logic                 ar_hs;
    logic                 aw_hs;
    logic                 ram_done;

    // offset form so the window may sit at the top of the map
    function automatic logic in_ram(input axi_pkg::addr_t addr);
        return (addr >= `RAM_BASE) && ((addr - `RAM_BASE) < `RAM_WORDS * 4);
    endfunction

    assign st_idle  = (state == axi_pkg::XB_IDLE);
    assign st_ram   = (state == axi_pkg::XB_RAM);
    assign st_err_r = (state == axi_pkg::XB_ERR_R);
    assign st_err_b = (state == axi_pkg::XB_ERR_B);

    assign ar_hit = in_ram(arb_araddr);
    assign aw_hit = in_ram(arb_awaddr);
    // reads win if both show up
    assign wr_sel = st_idle & ~arb_arvalid;

    assign ar_hs    = arb_arvalid & arb_arready;
    assign aw_hs    = arb_awvalid & arb_awready;
    assign ram_done = (ram_rvalid & ram_rready) | (ram_bvalid & ram_bready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= axi_pkg::XB_IDLE;
        end else begin
            case (state)
                axi_pkg::XB_IDLE: begin
                    if (ar_hs) begin
                        state <= ar_hit ? axi_pkg::XB_RAM : axi_pkg::XB_ERR_R;
                    end else if (aw_hs) begin
                        state <= aw_hit ? axi_pkg::XB_RAM : axi_pkg::XB_ERR_B;
                    end
                end
                axi_pkg::XB_RAM: begin
                    if (ram_done) begin
                        state <= axi_pkg::XB_IDLE;
                    end
                end
                axi_pkg::XB_ERR_R: begin
                    if (arb_rready) begin
                        state <= axi_pkg::XB_IDLE;
                    end
                end
                default: begin
                    if (arb_bready) begin
                        state <= axi_pkg::XB_IDLE;
                    end
                end
            endcase
        end
    end

    // requests to the ram, in-range only
    assign ram_araddr  = arb_araddr;
    assign ram_arvalid = st_idle & arb_arvalid & ar_hit;
    assign ram_awaddr  = arb_awaddr;
    assign ram_awvalid = wr_sel & arb_awvalid & aw_hit;
    assign ram_wdata   = arb_wdata;
    assign ram_wstrb   = arb_wstrb;
    assign ram_wvalid  = wr_sel & arb_wvalid & aw_hit;

    // out-of-range requests are swallowed here
    assign arb_arready = st_idle & (ar_hit ? ram_arready : 1'b1);
    assign arb_awready = wr_sel & (aw_hit ? ram_awready : (arb_awvalid & arb_wvalid));
    assign arb_wready  = wr_sel & (aw_hit ? ram_wready : (arb_awvalid & arb_wvalid));

    assign ram_rready = st_ram & arb_rready;
    assign ram_bready = st_ram & arb_bready;

    assign arb_rdata  = st_ram ? ram_rdata : '0;
    assign arb_rresp  = st_err_r ? axi_pkg::RESP_DECERR : ram_rresp;
    assign arb_rvalid = st_err_r | (st_ram & ram_rvalid);
    assign arb_bresp  = st_err_b ? axi_pkg::RESP_DECERR : ram_bresp;
    assign arb_bvalid = st_err_b | (st_ram & ram_bvalid);

    // no new request shows up while a decode error is still owed
    a_no_req_in_err: assert property (@(posedge clk) disable iff (!rst_n)
        (st_err_r || st_err_b) |-> !arb_arvalid && !arb_awvalid);

endmodule

`default_nettype wire

//--- verilog/axi_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_config.svh"

module axi_sram (
    input  logic            clk,
    input  logic            rst_n,

    input  axi_pkg::addr_t  ram_araddr,
    input  logic            ram_arvalid,
    output logic            ram_arready,
    output axi_pkg::data_t  ram_rdata,
    output axi_pkg::resp_e  ram_rresp,
    output logic            ram_rvalid,
    input  logic            ram_rready,
    input  axi_pkg::addr_t  ram_awaddr,
    input  logic            ram_awvalid,
    output logic            ram_awready,
    input  axi_pkg::data_t  ram_wdata,
    input  axi_pkg::strb_t  ram_wstrb,
    input  logic            ram_wvalid,
    output logic            ram_wready,
    output axi_pkg::resp_e  ram_bresp,
    output logic            ram_bvalid,
    input  logic            ram_bready
);

    localparam int OFF_W = $clog2(`AXI_STRB_W);
    localparam int IDX_W = $clog2(`RAM_WORDS);

    axi_pkg::data_t   mem [`RAM_WORDS];
    axi_pkg::data_t   rdata_q;
    logic             r_pend;
    logic             b_pend;
    logic             idle;
    logic             ar_hs;
    logic             wr_go;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx = ram_araddr[IDX_W+OFF_W-1:OFF_W];
    assign wr_idx = ram_awaddr[IDX_W+OFF_W-1:OFF_W];

    // one transaction at a time across both channels
    assign idle  = ~r_pend & ~b_pend;
    assign ar_hs = ram_arvalid & idle;
    assign wr_go = ram_awvalid & ram_wvalid & ~ram_arvalid & idle;

    assign ram_arready = idle;
    assign ram_awready = wr_go;
    assign ram_wready  = wr_go;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end else begin
            if (ar_hs) begin
                r_pend <= 1'b1;
            end else if (ram_rready) begin
                r_pend <= 1'b0;
            end
            if (wr_go) begin
                b_pend <= 1'b1;
            end else if (ram_bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= mem[rd_idx];
        end
        if (wr_go) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (ram_wstrb[i]) begin
                    mem[wr_idx][i*8 +: 8] <= ram_wdata[i*8 +: 8];
                end
            end
        end
    end

    assign ram_rdata  = rdata_q;
    assign ram_rresp  = axi_pkg::RESP_OKAY;
    assign ram_rvalid = r_pend;
    assign ram_bresp  = axi_pkg::RESP_OKAY;
    assign ram_bvalid = b_pend;

    // write response held until taken
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ram_bvalid && !ram_bready |=> ram_bvalid);

endmodule

`default_nettype wire

//--- verilog/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic            clk,
    input  logic            rst_n,

    input  axi_pkg::addr_t  fetch_araddr,
    input  logic            fetch_arvalid,
    output logic            fetch_arready,
    output axi_pkg::data_t  fetch_rdata,
    output axi_pkg::resp_e  fetch_rresp,
    output logic            fetch_rvalid,
    input  logic            fetch_rready,

    input  axi_pkg::addr_t  lsu_araddr,
    input  logic            lsu_arvalid,
    output logic            lsu_arready,
    output axi_pkg::data_t  lsu_rdata,
    output axi_pkg::resp_e  lsu_rresp,
    output logic            lsu_rvalid,
    input  logic            lsu_rready,
    input  axi_pkg::addr_t  lsu_awaddr,
    input  logic            lsu_awvalid,
    output logic            lsu_awready,
    input  axi_pkg::data_t  lsu_wdata,
    input  axi_pkg::strb_t  lsu_wstrb,
    input  logic            lsu_wvalid,
    output logic            lsu_wready,
    output axi_pkg::resp_e  lsu_bresp,
    output logic            lsu_bvalid,
    input  logic            lsu_bready
);

    // arbiter to xbar
    axi_pkg::addr_t arb_araddr;
    logic           arb_arvalid;
    logic           arb_arready;
    axi_pkg::data_t arb_rdata;
    axi_pkg::resp_e arb_rresp;
    logic           arb_rvalid;
    logic           arb_rready;
    axi_pkg::addr_t arb_awaddr;
    logic           arb_awvalid;
    logic           arb_awready;
    axi_pkg::data_t arb_wdata;
    axi_pkg::strb_t arb_wstrb;
    logic           arb_wvalid;
    logic           arb_wready;
    axi_pkg::resp_e arb_bresp;
    logic           arb_bvalid;
    logic           arb_bready;

    // xbar to ram
    axi_pkg::addr_t ram_araddr;
    logic           ram_arvalid;
    logic           ram_arready;
    axi_pkg::data_t ram_rdata;
    axi_pkg::resp_e ram_rresp;
    logic           ram_rvalid;
    logic           ram_rready;
    axi_pkg::addr_t ram_awaddr;
    logic           ram_awvalid;
    logic           ram_awready;
    axi_pkg::data_t ram_wdata;
    axi_pkg::strb_t ram_wstrb;
    logic           ram_wvalid;
    logic           ram_wready;
    axi_pkg::resp_e ram_bresp;
    logic           ram_bvalid;
    logic           ram_bready;

    // port names match the nets one to one
    arbiter u_arbiter (.*);

    xbar u_xbar (.*);

    axi_sram u_sram (.*);

endmodule

`default_nettype wire

//--- dv/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int TIMEOUT = 100;
    // handshake selectors
    localparam int F_AR = 0;
    localparam int F_R  = 1;
    localparam int L_AR = 2;
    localparam int L_R  = 3;
    localparam int L_W  = 4;
    localparam int L_B  = 5;

    logic clk;
    logic rst_n;
    axi_pkg::addr_t fetch_araddr;
    logic fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready;
    axi_pkg::data_t fetch_rdata;
    axi_pkg::resp_e fetch_rresp;
    axi_pkg::addr_t lsu_araddr, lsu_awaddr;
    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    axi_pkg::data_t lsu_rdata, lsu_wdata;
    axi_pkg::strb_t lsu_wstrb;
    axi_pkg::resp_e lsu_rresp, lsu_bresp;

    int    errors;
    int    cycle;
    bit    aborted;
    string cur_test;
    string test_names[5] = '{"write_readback", "byte_strobe", "decode_error",
                             "arb_priority", "back_pressure"};

    mem_subsys_top u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic sig_val(input int which);
        case (which)
            F_AR:    return fetch_arready;
            F_R:     return fetch_rvalid;
            L_AR:    return lsu_arready;
            L_R:     return lsu_rvalid;
            L_W:     return lsu_awready & lsu_wready;
            default: return lsu_bvalid;
        endcase
    endfunction

    function automatic axi_pkg::data_t rsp_data(input int which);
        return (which == F_R) ? fetch_rdata : (which == L_R) ? lsu_rdata : '0;
    endfunction

    function automatic axi_pkg::resp_e rsp_resp(input int which);
        return (which == F_R) ? fetch_rresp : (which == L_R) ? lsu_rresp : lsu_bresp;
    endfunction

    task automatic set_ready(input int which, input logic val);
        case (which)
            F_R:     fetch_rready = val;
            L_R:     lsu_rready = val;
            default: lsu_bready = val;
        endcase
    endtask

    task automatic check_data(input axi_pkg::data_t exp, input axi_pkg::data_t act);
        if (act !== exp) begin
            $display("error %s: expected data %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_resp(input axi_pkg::resp_e exp, input axi_pkg::resp_e act);
        if (act !== exp) begin
            $display("error %s: expected resp %0d, actual %0d", cur_test, exp, act);
            errors++;
        end
    endtask

    // sampled at the falling edge, the transfer lands on the next rising edge
    task automatic wait_high(input int which, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!sig_val(which)) begin
            n++;
            if (n >= TIMEOUT) begin
                $display("%s: no %s within %0d cycles", cur_test, what, TIMEOUT);
                aborted = 1'b1;
                return;
            end
            @(negedge clk);
        end
    endtask

    task automatic take_response(input int which, input bit bp,
                                 output axi_pkg::data_t data, output axi_pkg::resp_e resp);
        int stall;
        wait_high(which, "response");
        if (aborted) return;
        data = rsp_data(which);
        resp = rsp_resp(which);
        if (bp) begin
            stall = $urandom_range(1, 8);
            repeat (stall) begin
                @(negedge clk);
                if (!sig_val(which) || rsp_data(which) !== data || rsp_resp(which) !== resp) begin
                    $display("%s: response dropped or changed while ready was low", cur_test);
                    errors++;
                end
            end
            @(posedge clk);
            #1 set_ready(which, 1'b1);
        end
        @(posedge clk);
        #1 set_ready(which, 1'b0);
        @(negedge clk);
        if (sig_val(which)) begin
            $display("%s: a second response appeared after the handshake", cur_test);
            errors++;
        end
    endtask

    task automatic read_txn(input bit use_lsu, input axi_pkg::addr_t addr, input bit bp,
                            output axi_pkg::data_t data, output axi_pkg::resp_e resp);
        if (use_lsu) begin
            lsu_araddr  = addr;
            lsu_arvalid = 1'b1;
            lsu_rready  = !bp;
        end else begin
            fetch_araddr  = addr;
            fetch_arvalid = 1'b1;
            fetch_rready  = !bp;
        end
        wait_high(use_lsu ? L_AR : F_AR, "read address handshake");
        if (aborted) return;
        @(posedge clk);
        #1;
        lsu_arvalid   = use_lsu ? 1'b0 : lsu_arvalid;
        fetch_arvalid = use_lsu ? fetch_arvalid : 1'b0;
        take_response(use_lsu ? L_R : F_R, bp, data, resp);
    endtask

    task automatic write_txn(input axi_pkg::addr_t addr, input axi_pkg::data_t data,
                             input axi_pkg::strb_t strb, input bit bp,
                             output axi_pkg::resp_e resp);
        axi_pkg::data_t unused;
        lsu_awaddr  = addr;
        lsu_wdata   = data;
        lsu_wstrb   = strb;
        lsu_awvalid = 1'b1;
        lsu_wvalid  = 1'b1;
        lsu_bready  = !bp;
        wait_high(L_W, "write address and data handshake");
        if (aborted) return;
        @(posedge clk);
        #1;
        lsu_awvalid = 1'b0;
        lsu_wvalid  = 1'b0;
        take_response(L_B, bp, unused, resp);
    endtask

    initial begin
        int fd, lineno, fields, tests, errs_before, tid, bp, lsu_done, fetch_done;
        string line;
        byte op, mst;
        axi_pkg::addr_t addr;
        axi_pkg::data_t wdata, exp_data, got_data;
        axi_pkg::strb_t strb;
        logic [1:0] resp_raw;
        axi_pkg::resp_e exp_resp, got_resp, lsu_resp;
        void'($urandom(51333));
        clk = 1'b0;
        rst_n = 1'b0;
        {fetch_araddr, fetch_arvalid, fetch_rready} = '0;
        {lsu_araddr, lsu_arvalid, lsu_rready, lsu_awaddr, lsu_awvalid} = '0;
        {lsu_wdata, lsu_wstrb, lsu_wvalid, lsu_bready} = '0;
        errors = 0;
        cycle = 0;
        aborted = 1'b0;
        tests = 0;
        lineno = 0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        fd = $fopen("dv/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file dv/mem_trace.txt");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            lineno++;
            if (line.len() < 2 || line[0] == "#") continue;
            fields = $sscanf(line, "%c %c %h %h %h %h %h %d %d", op, mst, addr, wdata, strb,
                             exp_data, resp_raw, bp, tid);
            if (fields != 9 || tid < 0 || tid > 4) begin
                $display("trace line %0d cannot be parsed", lineno);
                aborted = 1'b1;
                break;
            end
            exp_resp = axi_pkg::resp_e'(resp_raw);
            cur_test = $sformatf("%s (line %0d)", test_names[tid], lineno);
            errs_before = errors;
            @(posedge clk);
            #1;
            case (op)
                "W": begin
                    write_txn(addr, wdata, strb, bp[0], got_resp);
                    if (!aborted) check_resp(exp_resp, got_resp);
                end
                "R": begin
                    read_txn(mst == "L", addr, bp[0], got_data, got_resp);
                    if (!aborted) begin
                        check_data(exp_data, got_data);
                        check_resp(exp_resp, got_resp);
                    end
                end
                "A": begin
                    // both masters request in the same cycle
                    fork
                        begin
                            write_txn(addr, wdata, strb, bp[0], lsu_resp);
                            lsu_done = cycle;
                        end
                        begin
                            read_txn(1'b0, addr, bp[0], got_data, got_resp);
                            fetch_done = cycle;
                        end
                    join
                    if (!aborted) begin
                        check_resp(exp_resp, lsu_resp);
                        check_data(exp_data, got_data);
                        check_resp(exp_resp, got_resp);
                        if (fetch_done <= lsu_done) begin
                            $display("%s: fetch finished before the lsu write", cur_test);
                            errors++;
                        end
                    end
                end
                default: begin
                    $display("trace line %0d has an unknown operation", lineno);
                    aborted = 1'b1;
                end
            endcase
            if (aborted) break;
            tests++;
            $display("%-28s %s", cur_test, (errors == errs_before) ? "ok" : "mismatch");
        end
        if (fd != 0) $fclose(fd);
        $display("tests run %0d, errors %0d, aborted %0d", tests, errors, aborted);
        if (aborted || errors != 0 || tests == 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/axi_pkg.sv
verilog/arbiter.sv
verilog/xbar.sv
verilog/axi_sram.sv
verilog/mem_subsys_top.sv
dv/tb_mem_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
RTL_TOP   ?= mem_subsys_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) verilog/axi_config.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/mem_trace.txt
# op (W write, R read, A lsu write with fetch read), master (F/L), addr, wdata, strb (hex)
# exp_data, exp_resp (0 okay, 3 decerr) in hex, back-pressure 0/1, test index (decimal)
W L 80000000 11223344 f 00000000 0 0 0
W L 80000004 a5a5a5a5 f 00000000 0 0 0
W L 800003fc deadbeef f 00000000 0 0 0
R F 80000000 00000000 0 11223344 0 0 0
R L 80000004 00000000 0 a5a5a5a5 0 0 0
R F 800003fc 00000000 0 deadbeef 0 0 0
W L 80000000 ffeeddcc 1 00000000 0 0 1
R L 80000000 00000000 0 112233cc 0 0 1
W L 80000004 00770000 4 00000000 0 0 1
R F 80000004 00000000 0 a577a5a5 0 0 1
W L 800003fc 12345678 a 00000000 0 0 1
R L 800003fc 00000000 0 12ad56ef 0 0 1
R F 80000400 00000000 0 00000000 3 0 2
R L 00001000 00000000 0 00000000 3 0 2
W L 7ffffffc cafef00d f 00000000 3 0 2
W L 80000400 cafef00d f 00000000 3 0 2
R F 80000000 00000000 0 112233cc 0 0 2
A L 80000008 0badf00d f 0badf00d 0 0 3
A L 8000000c 13572468 f 13572468 0 0 3
R L 8000000c 00000000 0 13572468 0 1 4
R F 80000008 00000000 0 0badf00d 0 1 4
W L 80000010 00c0ffee f 00000000 0 1 4
R F 80000010 00000000 0 00c0ffee 0 1 4
W L 80000010 0000ee00 2 00000000 0 1 4
R L 80000010 00000000 0 00c0eeee 0 1 4
W L 90000000 5a5a5a5a f 00000000 3 1 4
R L 90000000 00000000 0 00000000 3 1 4
